// File: Bender.yml
package:
  name: fetch_frontend

sources:
  # RTL, package first
  - files:
      - hw/fetch_pkg.sv
      - hw/bht.sv
      - hw/branch_scan.sv
      - hw/fetch_ctrl.sv
      - hw/fetch_queue.sv
      - hw/pc_gen.sv
      - hw/fetch_frontend.sv

  # testbench, top module tb_fetch_frontend
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_fetch_frontend.sv

// File: hw/bht.sv
`timescale 1ns/1ps

module bht import fetch_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic [XLEN-1:0] rd_pc_i,
    input  logic            resolve_valid_i,
    input  logic [XLEN-1:0] resolve_pc_i,
    input  logic            resolve_taken_i,
    output logic            counter_taken_o
);

    // 2-bit saturating counters, upper bit is the prediction
    logic [1:0]           cnt_q [BHT_ENTRIES];
    logic [BHT_IDX_W-1:0] rd_idx;
    logic [BHT_IDX_W-1:0] wr_idx;
    logic [1:0]           wr_cnt;

    // word aligned pcs, skip the two offset bits
    assign rd_idx = rd_pc_i[BHT_IDX_W+1:2];
    assign wr_idx = resolve_pc_i[BHT_IDX_W+1:2];

    // ------------------------------------------------------------------
    // read
    // ------------------------------------------------------------------
    // reads see the old value when the same entry is written
    assign counter_taken_o = cnt_q[rd_idx][1];

    // ------------------------------------------------------------------
    // update
    // ------------------------------------------------------------------
    always_comb begin
        wr_cnt = cnt_q[wr_idx];
        if (resolve_taken_i) begin
            // saturate at strongly taken
            if (wr_cnt != 2'b11) begin
                wr_cnt = wr_cnt + 2'd1;
            end
        end else begin
            // saturate at strongly not taken
            if (wr_cnt != 2'b00) begin
                wr_cnt = wr_cnt - 2'd1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < BHT_ENTRIES; i++) begin
                cnt_q[i] <= BHT_RESET;
            end
        end else if (resolve_valid_i) begin
            cnt_q[wr_idx] <= wr_cnt;
        end
    end

endmodule

// File: hw/branch_scan.sv
`timescale 1ns/1ps

module branch_scan import fetch_pkg::*; (
    input  logic [XLEN-1:0] instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic            counter_taken_i,
    output logic            pred_taken_o,
    output logic [XLEN-1:0] pred_target_o
);

    fetch_instr_u    word;
    logic            is_branch;
    logic            is_jal;
    logic [XLEN-1:0] imm_b;
    logic [XLEN-1:0] imm_j;
    logic [XLEN-1:0] offset;

    assign word = instr_i;

    // ------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------
    // opcode sits at the same place in both views
    assign is_branch = (word.b.opcode == OPC_BRANCH);
    assign is_jal    = (word.j.opcode == OPC_JAL);

    // B-type offset, 13 bits signed, bit 0 always zero
    assign imm_b = {{(XLEN-12){word.b.imm12}}, word.b.imm11, word.b.imm10_5,
                    word.b.imm4_1, 1'b0};

    // J-type offset, 21 bits signed, bit 0 always zero
    assign imm_j = {{(XLEN-20){word.j.imm20}}, word.j.imm19_12, word.j.imm11,
                    word.j.imm10_1, 1'b0};

    // ------------------------------------------------------------------
    // prediction
    // ------------------------------------------------------------------
    // jal always taken, a branch follows its counter
    assign pred_taken_o = is_jal | (is_branch & counter_taken_i);

    // a branch predicted not taken still reports its own target
    // other words point at the next word
    always_comb begin
        if (is_jal) begin
            offset = imm_j;
        end else if (is_branch) begin
            offset = imm_b;
        end else begin
            offset = XLEN'(4);
        end
    end

    assign pred_target_o = pc_i + offset;

endmodule

// File: hw/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl import fetch_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              imem_ready_i,
    input  logic              imem_valid_i,
    input  logic              trap_i,
    input  logic              resolve_valid_i,
    input  logic              resolve_mispredict_i,
    input  logic [QCNT_W-1:0] queue_count_i,
    output logic              imem_req_o,
    output logic              rsp_accept_o,
    output logic              redirect_o,
    output logic              queue_push_o,
    output logic              queue_flush_o
);

    // enables fetching one cycle out of reset, when the boot pc is loaded
    logic run_q;
    // a request was accepted and its response has not come back yet
    logic outstanding_q;
    // the outstanding response belongs to a pc before a redirect
    logic stale_q;
    logic req_accept;

    // ------------------------------------------------------------------
    // redirect and request
    // ------------------------------------------------------------------
    // trap or a valid mispredict from the back end
    assign redirect_o    = trap_i | (resolve_valid_i & resolve_mispredict_i);
    assign queue_flush_o = redirect_o;

    // only one request in flight, and only with a free queue slot for its answer
    // no request in the redirect cycle, the new pc is loaded at its end
    assign imem_req_o = run_q & ~outstanding_q & ~redirect_o
                      & (queue_count_i < QCNT_W'(QUEUE_DEPTH));
    assign req_accept = imem_req_o & imem_ready_i;

    // stale answers and answers in a redirect cycle are dropped
    assign rsp_accept_o = imem_valid_i & ~stale_q & ~redirect_o;
    assign queue_push_o = rsp_accept_o;

    // ------------------------------------------------------------------
    // outstanding and stale tracking
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            run_q         <= 1'b0;
            outstanding_q <= 1'b0;
            stale_q       <= 1'b0;
        end else begin
            run_q <= 1'b1;
            // a zero latency answer clears the request it belongs to
            if (imem_valid_i) begin
                outstanding_q <= 1'b0;
            end else if (req_accept) begin
                outstanding_q <= 1'b1;
            end
            // answer consumed, whether used or dropped
            if (imem_valid_i) begin
                stale_q <= 1'b0;
            end else if (redirect_o && outstanding_q) begin
                stale_q <= 1'b1;
            end
        end
    end

endmodule

// File: hw/fetch_frontend.sv
`timescale 1ns/1ps

module fetch_frontend import fetch_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic [XLEN-1:0] boot_addr_i,
    // instruction memory
    output logic            imem_req_o,
    output logic [XLEN-1:0] imem_addr_o,
    input  logic            imem_ready_i,
    input  logic            imem_valid_i,
    input  logic [XLEN-1:0] imem_data_i,
    // resolved branches from the back end
    input  logic            resolve_valid_i,
    input  logic [XLEN-1:0] resolve_pc_i,
    input  logic            resolve_taken_i,
    input  logic            resolve_mispredict_i,
    input  logic [XLEN-1:0] resolve_target_i,
    // trap
    input  logic            trap_i,
    input  logic [XLEN-1:0] trap_vector_i,
    // decode
    output logic            fetch_valid_o,
    input  logic            fetch_ready_i,
    output logic [XLEN-1:0] fetch_pc_o,
    output logic [XLEN-1:0] fetch_instr_o,
    output logic            fetch_taken_o,
    output logic [XLEN-1:0] fetch_target_o
);

    logic              rsp_accept;
    logic              redirect;
    logic              queue_push;
    logic              queue_flush;
    logic [QCNT_W-1:0] queue_count;
    logic [XLEN-1:0]   pc;
    logic              counter_taken;
    logic              pred_taken;
    logic [XLEN-1:0]   pred_target;

    // request address is the pc register itself
    assign imem_addr_o = pc;

    // ------------------------------------------------------------------
    // control and pc
    // ------------------------------------------------------------------
    fetch_ctrl i_fetch_ctrl (
        .clk_i                ( clk_i                ),
        .rst_ni               ( rst_ni               ),
        .imem_ready_i         ( imem_ready_i         ),
        .imem_valid_i         ( imem_valid_i         ),
        .trap_i               ( trap_i               ),
        .resolve_valid_i      ( resolve_valid_i      ),
        .resolve_mispredict_i ( resolve_mispredict_i ),
        .queue_count_i        ( queue_count          ),
        .imem_req_o           ( imem_req_o           ),
        .rsp_accept_o         ( rsp_accept           ),
        .redirect_o           ( redirect             ),
        .queue_push_o         ( queue_push           ),
        .queue_flush_o        ( queue_flush          )
    );

    pc_gen i_pc_gen (
        .clk_i            ( clk_i            ),
        .rst_ni           ( rst_ni           ),
        .boot_addr_i      ( boot_addr_i      ),
        .rsp_accept_i     ( rsp_accept       ),
        .redirect_i       ( redirect         ),
        .trap_i           ( trap_i           ),
        .trap_vector_i    ( trap_vector_i    ),
        .resolve_target_i ( resolve_target_i ),
        .pred_taken_i     ( pred_taken       ),
        .pred_target_i    ( pred_target      ),
        .pc_o             ( pc               )
    );

    // ------------------------------------------------------------------
    // prediction on the returned word
    // ------------------------------------------------------------------
    // pc still holds the address of the word being answered
    bht i_bht (
        .clk_i           ( clk_i           ),
        .rst_ni          ( rst_ni          ),
        .rd_pc_i         ( pc              ),
        .resolve_valid_i ( resolve_valid_i ),
        .resolve_pc_i    ( resolve_pc_i    ),
        .resolve_taken_i ( resolve_taken_i ),
        .counter_taken_o ( counter_taken   )
    );

    branch_scan i_branch_scan (
        .instr_i         ( imem_data_i   ),
        .pc_i            ( pc            ),
        .counter_taken_i ( counter_taken ),
        .pred_taken_o    ( pred_taken    ),
        .pred_target_o   ( pred_target   )
    );

    // queue towards decode
    fetch_queue i_fetch_queue (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .push_i         ( queue_push     ),
        .flush_i        ( queue_flush    ),
        .pc_i           ( pc             ),
        .instr_i        ( imem_data_i    ),
        .taken_i        ( pred_taken     ),
        .target_i       ( pred_target    ),
        .fetch_ready_i  ( fetch_ready_i  ),
        .count_o        ( queue_count    ),
        .fetch_valid_o  ( fetch_valid_o  ),
        .fetch_pc_o     ( fetch_pc_o     ),
        .fetch_instr_o  ( fetch_instr_o  ),
        .fetch_taken_o  ( fetch_taken_o  ),
        .fetch_target_o ( fetch_target_o )
    );

endmodule

// File: hw/fetch_pkg.sv
package fetch_pkg;

    // ------------------------------------------------------------------
    // widths and sizes
    // ------------------------------------------------------------------
    // address and data width of the fetch path
    localparam int unsigned XLEN = 32;

    // fetch queue towards decode
    localparam int unsigned QUEUE_DEPTH = 4;
    localparam int unsigned QPTR_W      = $clog2(QUEUE_DEPTH);
    // count has to hold the value QUEUE_DEPTH itself
    localparam int unsigned QCNT_W      = $clog2(QUEUE_DEPTH + 1);

    // branch history table, indexed by pc bits just above the word offset
    localparam int unsigned BHT_IDX_W   = 4;
    localparam int unsigned BHT_ENTRIES = 1 << BHT_IDX_W;
    // weakly not taken
    localparam logic [1:0]  BHT_RESET   = 2'b01;

    // ------------------------------------------------------------------
    // opcodes
    // ------------------------------------------------------------------
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    // one instruction word, seen as B-type or as J-type
    // both views keep the opcode in bits 6:0
    typedef union packed {
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } fetch_instr_u;

endpackage

// File: hw/fetch_queue.sv
`timescale 1ns/1ps

module fetch_queue import fetch_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              push_i,
    input  logic              flush_i,
    input  logic [XLEN-1:0]   pc_i,
    input  logic [XLEN-1:0]   instr_i,
    input  logic              taken_i,
    input  logic [XLEN-1:0]   target_i,
    input  logic              fetch_ready_i,
    output logic [QCNT_W-1:0] count_o,
    output logic              fetch_valid_o,
    output logic [XLEN-1:0]   fetch_pc_o,
    output logic [XLEN-1:0]   fetch_instr_o,
    output logic              fetch_taken_o,
    output logic [XLEN-1:0]   fetch_target_o
);

    // entry storage
    logic [XLEN-1:0]   pc_q     [QUEUE_DEPTH];
    logic [XLEN-1:0]   instr_q  [QUEUE_DEPTH];
    logic              taken_q  [QUEUE_DEPTH];
    logic [XLEN-1:0]   target_q [QUEUE_DEPTH];

    logic [QPTR_W-1:0] rd_ptr_q;
    logic [QPTR_W-1:0] wr_ptr_q;
    logic [QCNT_W-1:0] count_q;
    logic              full;
    logic              do_push;
    logic              do_pop;

    assign full    = (count_q == QCNT_W'(QUEUE_DEPTH));
    // fetch_ctrl keeps space for every answer, the check only guards the storage
    assign do_push = push_i & ~full;
    assign do_pop  = fetch_valid_o & fetch_ready_i;

    // ------------------------------------------------------------------
    // head of queue to decode
    // ------------------------------------------------------------------
    assign count_o        = count_q;
    assign fetch_valid_o  = (count_q != '0);
    assign fetch_pc_o     = pc_q[rd_ptr_q];
    assign fetch_instr_o  = instr_q[rd_ptr_q];
    assign fetch_taken_o  = taken_q[rd_ptr_q];
    assign fetch_target_o = target_q[rd_ptr_q];

    // ------------------------------------------------------------------
    // pointers and count
    // ------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            // flush drops everything, a push in the same cycle included
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == QPTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            // push and pop together leave the count as it is
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (!do_push && do_pop) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // payload written at the tail
    always_ff @(posedge clk_i) begin
        if (do_push) begin
            pc_q[wr_ptr_q]     <= pc_i;
            instr_q[wr_ptr_q]  <= instr_i;
            taken_q[wr_ptr_q]  <= taken_i;
            target_q[wr_ptr_q] <= target_i;
        end
    end

endmodule

// File: hw/pc_gen.sv
`timescale 1ns/1ps

module pc_gen import fetch_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic [XLEN-1:0] boot_addr_i,
    input  logic            rsp_accept_i,
    input  logic            redirect_i,
    input  logic            trap_i,
    input  logic [XLEN-1:0] trap_vector_i,
    input  logic [XLEN-1:0] resolve_target_i,
    input  logic            pred_taken_i,
    input  logic [XLEN-1:0] pred_target_i,
    output logic [XLEN-1:0] pc_o
);

    logic [XLEN-1:0] pc_d;
    logic [XLEN-1:0] pc_q;
    // set while in reset, so the first cycle out of reset loads boot_addr_i
    logic            boot_load_q;

    // pc of the outstanding request, also the pc of the word coming back
    assign pc_o = pc_q;

    // ------------------------------------------------------------------
    // next pc, lowest priority first
    // ------------------------------------------------------------------
    always_comb begin
        // hold, or boot address right after reset
        if (boot_load_q) begin
            pc_d = boot_addr_i;
        end else begin
            pc_d = pc_q;
        end
        // accepted word moves on to the predicted target or the next word
        if (rsp_accept_i) begin
            if (pred_taken_i) begin
                pc_d = pred_target_i;
            end else begin
                pc_d = pc_q + XLEN'(4);
            end
        end
        // back end wins, trap over mispredict
        if (redirect_i) begin
            if (trap_i) begin
                pc_d = trap_vector_i;
            end else begin
                pc_d = resolve_target_i;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            boot_load_q <= 1'b1;
            pc_q        <= '0;
        end else begin
            boot_load_q <= 1'b0;
            pc_q        <= pc_d;
        end
    end

endmodule

// File: project.f
+incdir+tb
hw/fetch_pkg.sv
hw/bht.sv
hw/branch_scan.sv
hw/fetch_ctrl.sv
hw/fetch_queue.sv
hw/pc_gen.sv
hw/fetch_frontend.sv
tb/tb_fetch_frontend.sv

// File: tb/tb_fetch_ref.svh
`ifndef TB_FETCH_REF_SVH
`define TB_FETCH_REF_SVH

// ----------------------------------------------------------------------
// reference decode, straight from the RV32I B-type and J-type layouts
// ----------------------------------------------------------------------
function automatic logic [XLEN-1:0] ref_offset(input logic [XLEN-1:0] word);
    fetch_instr_u w;
    w = word;
    if (w.j.opcode == OPC_JAL) begin
        // 21-bit signed jump offset
        return {{12{w.j.imm20}}, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};
    end
    if (w.b.opcode == OPC_BRANCH) begin
        // 13-bit signed branch offset
        return {{20{w.b.imm12}}, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
    end
    // anything else just falls through to the next word
    return XLEN'(4);
endfunction

// jal always taken, a branch when its counter is in a taken state
function automatic logic ref_taken(input logic [XLEN-1:0] word, input logic [1:0] cnt);
    fetch_instr_u w;
    w = word;
    return (w.j.opcode == OPC_JAL) || ((w.b.opcode == OPC_BRANCH) && cnt[1]);
endfunction

function automatic logic [XLEN-1:0] ref_target(input logic [XLEN-1:0] word,
                                               input logic [XLEN-1:0] pc);
    return pc + ref_offset(word);
endfunction

// 2-bit saturating counter step
function automatic logic [1:0] ref_counter_next(input logic [1:0] cnt, input logic taken);
    if (taken) begin
        return (cnt == 2'b11) ? cnt : cnt + 2'd1;
    end
    return (cnt == 2'b00) ? cnt : cnt - 2'd1;
endfunction

// counter index, word pc bits above the byte offset
function automatic int ref_bht_index(input logic [XLEN-1:0] pc);
    return int'(pc[BHT_IDX_W+1:2]);
endfunction

`endif

// File: tb/tb_fetch_frontend.sv
`timescale 1ns/1ps

module tb_fetch_frontend import fetch_pkg::*; ();

    `include "tb_fetch_ref.svh"

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int MEM_WORDS    = 256;
    localparam int FILL_CYCLES  = 60;
    // entries compared in the boot, loop, loop exit, trap and mispredict phases
    localparam int TEST_INSTRS  = 12 + 12 + 8 + 8 + 16;
    localparam int WORST_CYCLES = 16;
    localparam int WATCHDOG_NS  = (TEST_INSTRS * WORST_CYCLES + 400) * CLK_PERIOD;

    localparam logic [XLEN-1:0] BOOT_ADDR  = 32'h100;
    localparam logic [XLEN-1:0] LOOP_START = 32'h150;
    localparam logic [XLEN-1:0] BR_PC      = 32'h158;
    localparam logic [XLEN-1:0] OTHER_PC   = 32'h3c0;
    localparam logic [XLEN-1:0] FWD_START  = 32'h200;
    localparam logic [XLEN-1:0] TRAP_VEC   = 32'h300;

    logic            clk_i;
    logic            rst_ni;
    logic [XLEN-1:0] boot_addr_i;
    logic            imem_req_o;
    logic [XLEN-1:0] imem_addr_o;
    logic            imem_ready_i;
    logic            imem_valid_i;
    logic [XLEN-1:0] imem_data_i;
    logic            resolve_valid_i;
    logic [XLEN-1:0] resolve_pc_i;
    logic            resolve_taken_i;
    logic            resolve_mispredict_i;
    logic [XLEN-1:0] resolve_target_i;
    logic            trap_i;
    logic [XLEN-1:0] trap_vector_i;
    logic            fetch_valid_o;
    logic            fetch_ready_i;
    logic [XLEN-1:0] fetch_pc_o;
    logic [XLEN-1:0] fetch_instr_o;
    logic            fetch_taken_o;
    logic [XLEN-1:0] fetch_target_o;

    integer          seed;
    logic [XLEN-1:0] mem [MEM_WORDS];
    // counter table model that follows every resolve driven
    logic [1:0]      cnt_tab [BHT_ENTRIES];
    logic [XLEN-1:0] exp_pc_q [$];
    logic            hold_ready;
    int              value_errors;
    int              other_errors;
    int              accept_count;
    // memory model state for the one request in flight
    logic            pend;
    int              pend_wait;
    logic [XLEN-1:0] pend_addr;

    fetch_frontend dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ------------------------------------------------------------------
    // program image and reference stream
    // ------------------------------------------------------------------
    function automatic logic [XLEN-1:0] encode_branch(input int offset);
        fetch_instr_u w;
        w           = '0;
        w.b.opcode  = OPC_BRANCH;
        w.b.rs1     = 5'd1;
        w.b.rs2     = 5'd2;
        w.b.imm12   = offset[12];
        w.b.imm11   = offset[11];
        w.b.imm10_5 = offset[10:5];
        w.b.imm4_1  = offset[4:1];
        return w;
    endfunction

    function automatic logic [XLEN-1:0] encode_jal(input int offset);
        fetch_instr_u w;
        w            = '0;
        w.j.opcode   = OPC_JAL;
        w.j.rd       = 5'd1;
        w.j.imm20    = offset[20];
        w.j.imm19_12 = offset[19:12];
        w.j.imm11    = offset[11];
        w.j.imm10_1  = offset[10:1];
        return w;
    endfunction

    function automatic logic [XLEN-1:0] mem_word(input logic [XLEN-1:0] addr);
        return mem[addr[9:2]];
    endfunction

    task automatic load_program();
        logic [XLEN-1:0] addr;
        // op-imm filler with the word address in the upper bits
        for (int i = 0; i < MEM_WORDS; i++) begin
            addr   = XLEN'(i * 4);
            mem[i] = {addr[26:2], 7'b0010011};
        end
        mem[32'h110 >> 2] = encode_jal(32'h40);
        // backward branch that loops back to 0x140
        mem[BR_PC >> 2]   = encode_branch(-24);
        // forward branch over three words and a jal behind them
        mem[32'h208 >> 2] = encode_branch(32'h10);
        mem[32'h218 >> 2] = encode_jal(32'h30);
    endtask

    // expected pc sequence along the reference prediction
    task automatic build_stream(input logic [XLEN-1:0] start, input int count);
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] word;
        pc = start;
        for (int i = 0; i < count; i++) begin
            word = mem_word(pc);
            exp_pc_q.push_back(pc);
            if (ref_taken(word, cnt_tab[ref_bht_index(pc)])) begin
                pc = ref_target(word, pc);
            end else begin
                pc = pc + XLEN'(4);
            end
        end
    endtask

    // ------------------------------------------------------------------
    // compare
    // ------------------------------------------------------------------
    task automatic check_field(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
            value_errors++;
        end
    endtask

    task automatic compare_entry();
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] word;
        logic [1:0]      cnt;
        pc   = exp_pc_q.pop_front();
        word = mem_word(pc);
        cnt  = cnt_tab[ref_bht_index(pc)];
        check_field("fetch_pc_o", pc, fetch_pc_o);
        check_field("fetch_instr_o", word, fetch_instr_o);
        check_field("fetch_taken_o", XLEN'(ref_taken(word, cnt)), XLEN'(fetch_taken_o));
        check_field("fetch_target_o", ref_target(word, pc), fetch_target_o);
    endtask

    // memory model and decode side act on the values from before the edge
    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            imem_ready_i  <= 1'b0;
            imem_valid_i  <= 1'b0;
            imem_data_i   <= '0;
            fetch_ready_i <= 1'b0;
            pend          = 1'b0;
            pend_wait     = 0;
        end else begin
            if (fetch_valid_o && fetch_ready_i) begin
                compare_entry();
            end
            if (imem_req_o && imem_ready_i) begin
                pend      = 1'b1;
                pend_addr = imem_addr_o;
                pend_wait = $random(seed) & 3;
                accept_count++;
            end
            // answer after 0 to 3 wait cycles
            if (pend && pend_wait == 0) begin
                imem_valid_i <= 1'b1;
                imem_data_i  <= mem_word(pend_addr);
                pend = 1'b0;
            end else begin
                imem_valid_i <= 1'b0;
                if (pend) begin
                    pend_wait--;
                end
            end
            imem_ready_i  <= ($random(seed) & 3) != 0;
            // decode only takes what the current stream still expects
            fetch_ready_i <= !hold_ready && (exp_pc_q.size() != 0)
                             && (($random(seed) & 3) != 0);
        end
    end

    // ------------------------------------------------------------------
    // back end and sequence
    // ------------------------------------------------------------------
    task automatic drive_resolve(input logic [XLEN-1:0] pc, input logic taken,
                                 input logic mispredict, input logic trap,
                                 input logic [XLEN-1:0] target);
        @(posedge clk_i);
        resolve_valid_i      <= 1'b1;
        resolve_pc_i         <= pc;
        resolve_taken_i      <= taken;
        resolve_mispredict_i <= mispredict;
        resolve_target_i     <= target;
        trap_i               <= trap;
        cnt_tab[ref_bht_index(pc)] = ref_counter_next(cnt_tab[ref_bht_index(pc)], taken);
        @(posedge clk_i);
        resolve_valid_i      <= 1'b0;
        resolve_mispredict_i <= 1'b0;
        trap_i               <= 1'b0;
    endtask

    // the queue is flushed by now and requests count for the new stream only
    task automatic redirect_and_expect(input logic [XLEN-1:0] rpc, input logic trap,
                                       input logic [XLEN-1:0] target,
                                       input logic [XLEN-1:0] start, input int count);
        drive_resolve(rpc, 1'b0, 1'b1, trap, target);
        @(negedge clk_i);
        accept_count = 0;
        build_stream(start, count);
    endtask

    task automatic wait_drained();
        while (exp_pc_q.size() != 0) begin
            @(negedge clk_i);
        end
    endtask

    // fetching has to stop with exactly a full queue while decode is stalled
    task automatic check_fill(input int expected_accepts);
        repeat (FILL_CYCLES) @(negedge clk_i);
        assert (fetch_valid_o && accept_count == expected_accepts) else begin
            $display("%0t: fetch did not stop with a full queue, %0d requests instead of %0d",
                     $time, accept_count, expected_accepts);
            other_errors++;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the fetch stream never completed",
                 WATCHDOG_NS);
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        seed                 = 32'h462c;
        value_errors         = 0;
        other_errors         = 0;
        accept_count         = 0;
        hold_ready           = 1'b0;
        rst_ni               = 1'b0;
        boot_addr_i          = BOOT_ADDR;
        imem_ready_i         = 1'b0;
        imem_valid_i         = 1'b0;
        imem_data_i          = '0;
        resolve_valid_i      = 1'b0;
        resolve_pc_i         = '0;
        resolve_taken_i      = 1'b0;
        resolve_mispredict_i = 1'b0;
        resolve_target_i     = '0;
        trap_i               = 1'b0;
        trap_vector_i        = TRAP_VEC;
        fetch_ready_i        = 1'b0;
        load_program();
        for (int i = 0; i < BHT_ENTRIES; i++) begin
            cnt_tab[i] = BHT_RESET;
        end
        repeat (RESET_CYCLES) @(posedge clk_i);
        rst_ni <= 1'b1;

        // boot through straight line code, a jal and a branch not taken
        @(negedge clk_i);
        build_stream(BOOT_ADDR, 12);
        wait_drained();
        check_fill(12 + QUEUE_DEPTH);

        // two taken resolves turn the loop branch taken
        drive_resolve(BR_PC, 1'b1, 1'b0, 1'b0, '0);
        drive_resolve(BR_PC, 1'b1, 1'b0, 1'b0, '0);
        redirect_and_expect(OTHER_PC, 1'b0, LOOP_START, LOOP_START, 12);
        // decode stalled first and let go after the fill
        hold_ready = 1'b1;
        check_fill(QUEUE_DEPTH);
        hold_ready = 1'b0;
        wait_drained();

        // two not taken resolves drop it back
        drive_resolve(BR_PC, 1'b0, 1'b0, 1'b0, '0);
        drive_resolve(BR_PC, 1'b0, 1'b0, 1'b0, '0);
        redirect_and_expect(OTHER_PC, 1'b0, LOOP_START, LOOP_START, 8);
        wait_drained();

        // trap and mispredict together while fetch is still running
        redirect_and_expect(OTHER_PC, 1'b1, FWD_START, TRAP_VEC, 8);
        wait_drained();
        redirect_and_expect(OTHER_PC, 1'b0, FWD_START, FWD_START, 16);
        wait_drained();

        repeat (4) @(negedge clk_i);
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
